//--- preview_link_top.f
+incdir+.
preview_link_pkg.sv
cmd_word_assembler.sv
crop_register_bank.sv
pixel_crop_tracker.sv
pixel_fifo.sv
frame_sequencer.sv
preview_link_top.sv
preview_link_tb.sv

//--- Makefile
TOP       ?= preview_link_tb
FILELIST  ?= preview_link_top.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)

//--- preview_link_tb.sv
`include "preview_link_defs.svh"

module preview_link_tb
    import preview_link_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] CMD_NONE     = 2'd0;
    localparam logic [1:0] CMD_CORNER   = 2'd1;
    localparam logic [1:0] CMD_BAD_ADDR = 2'd2;
    localparam int         NUM_ROWS     = 6;

    // one row of the stimulus table
    typedef struct packed {
        logic [1:0]  kind;
        logic [15:0] col;
        logic [15:0] row;
        logic [3:0]  frames;
        logic        rand_ready;
        logic [3:0]  gap;
        logic [7:0]  partial;
    } stim_row_t;

    logic        core_clk = 1'b0;
    logic        sys_reset;
    host_byte_t  host_byte_i;
    logic        host_byte_valid_i;
    pixel_t      pix_i;
    logic        pix_valid_i;
    logic        pix_sof_i;
    host_byte_t  tx_byte_o;
    logic        tx_valid_o;
    logic        tx_ready_i;
    logic        overflow_o;
    logic        rand_ready_mode;
    logic [31:0] rng_state = 32'hb4ca_fe88;
    stim_row_t   stim [NUM_ROWS];
    host_byte_t  exp_q [$];
    int          value_errs = 0;
    int          stream_errs = 0;
    int          check_errs = 0;
    int          byte_idx = 0;
    logic        held_last = 1'b0;
    host_byte_t  held_byte = '0;
    logic        overflow_seen = 1'b0;

    preview_link_top i_preview_link_top (.*);

    always #4 core_clk = ~core_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic pixel_t raw_value(input int r, input int c);
        return pixel_t'((r * `PL_RAW_WIDTH + c) % 256);
    endfunction

    // header first, then the window in raster order
    function automatic void push_frame(input int col0, input int row0);
        logic [63:0] magic;
        magic = "BIVFRAME";
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(magic[63 - 8 * i -: 8]);
        end
        for (int r = row0; r < row0 + `PL_ROI_HEIGHT; r++) begin
            for (int c = col0; c < col0 + `PL_ROI_WIDTH; c++) begin
                exp_q.push_back(raw_value(r, c));
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // stimulus drivers
    task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = 0; i < `PL_CMD_BYTES; i++) begin
            @(posedge core_clk);
            host_byte_i       <= word[47 - 8 * i -: 8];
            host_byte_valid_i <= 1'b1;
        end
        @(posedge core_clk);
        host_byte_valid_i <= 1'b0;
    endtask

    // sof on pixel 0 and optional idle cycles after each pixel
    task automatic send_frame(input int npix, input int gap);
        for (int i = 0; i < npix; i++) begin
            @(posedge core_clk);
            pix_i       <= raw_value(i / `PL_RAW_WIDTH, i % `PL_RAW_WIDTH);
            pix_valid_i <= 1'b1;
            pix_sof_i   <= (i == 0);
            repeat (gap) begin
                @(posedge core_clk);
                pix_valid_i <= 1'b0;
                pix_sof_i   <= 1'b0;
            end
        end
        @(posedge core_clk);
        pix_valid_i <= 1'b0;
        pix_sof_i   <= 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_cycles) begin
            @(posedge core_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected output bytes never arrived", exp_q.size());
            check_errs++;
            exp_q.delete();
        end
    endtask

    // host side back-pressure with about three cycles in four ready
    initial begin
        tx_ready_i <= 1'b1;
        forever begin
            @(posedge core_clk);
            if (rand_ready_mode) begin
                rng_state = xorshift32(rng_state);
                tx_ready_i <= (rng_state[1:0] != 2'b00);
            end else begin
                tx_ready_i <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // output collector
    always @(posedge core_clk) begin
        host_byte_t exp_byte;
        if (!sys_reset) begin
            if (held_last) begin
                assert (tx_valid_o && tx_byte_o == held_byte) else begin
                    $display("output byte dropped or changed while stalled at %0d ns", $time);
                    stream_errs++;
                end
            end
            if (tx_valid_o && tx_ready_i) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected output byte %h at %0d ns", tx_byte_o, $time);
                    stream_errs++;
                end
                if (exp_q.size() != 0) begin
                    exp_byte = exp_q.pop_front();
                    assert (tx_byte_o == exp_byte) else begin
                        $display("** Error %0d ns: output byte %0d is %h, expected %h",
                                 $time, byte_idx, tx_byte_o, exp_byte);
                        value_errs++;
                    end
                end
                byte_idx++;
            end
            held_last = tx_valid_o && !tx_ready_i;
            held_byte = tx_byte_o;
            // overflow is sticky, so report only its rising edge
            assert (!overflow_o || overflow_seen) else begin
                $display("pixel buffer overflowed at %0d ns", $time);
                check_errs++;
            end
            overflow_seen = overflow_o;
        end
    end

    initial begin
        stim_row_t cur;
        int        cur_col;
        int        cur_row;
        stim[0] = '{CMD_NONE,     16'd0, 16'd0, 4'd1, 1'b0, 4'd0, 8'd0};
        stim[1] = '{CMD_CORNER,   16'd0, 16'd4, 4'd2, 1'b0, 4'd0, 8'd0};
        stim[2] = '{CMD_BAD_ADDR, 16'd8, 16'd2, 4'd1, 1'b0, 4'd0, 8'd0};
        stim[3] = '{CMD_CORNER,   16'd8, 16'd2, 4'd2, 1'b1, 4'd1, 8'd0};
        stim[4] = '{CMD_CORNER,   16'd2, 16'd3, 4'd1, 1'b0, 4'd0, 8'd40};
        stim[5] = '{CMD_CORNER,   16'd5, 16'd1, 4'd2, 1'b1, 4'd1, 8'd3};
        cur_col = `PL_DEF_COL_START;
        cur_row = `PL_DEF_ROW_START;
        sys_reset         <= 1'b1;
        host_byte_i       <= '0;
        host_byte_valid_i <= 1'b0;
        pix_i             <= '0;
        pix_valid_i       <= 1'b0;
        pix_sof_i         <= 1'b0;
        rand_ready_mode   <= 1'b0;
        repeat (8) @(posedge core_clk);
        sys_reset <= 1'b0;
        @(posedge core_clk);
        assert (!tx_valid_o && !overflow_o) else begin
            $display("outputs not idle after reset");
            check_errs++;
        end
        for (int n = 0; n < NUM_ROWS; n++) begin
            cur = stim[n];
            rand_ready_mode <= cur.rand_ready;
            // the upper data half is junk and only the low 16 bits count
            if (cur.kind == CMD_CORNER) begin
                send_cmd(`PL_ADDR_COL_START, {16'ha5a5, cur.col});
                send_cmd(`PL_ADDR_ROW_START, {16'h5a5a, cur.row});
                cur_col = int'(cur.col);
                cur_row = int'(cur.row);
            end else if (cur.kind == CMD_BAD_ADDR) begin
                send_cmd(16'h0012, {16'h0000, cur.col});
                send_cmd(16'h0110, {16'h0000, cur.row});
            end
            repeat (4) @(posedge core_clk);
            // truncated frame that ends before the window corner
            if (cur.partial != 8'd0) begin
                send_frame(int'(cur.partial), int'(cur.gap));
            end
            for (int f = 0; f < int'(cur.frames); f++) begin
                push_frame(cur_col, cur_row);
                send_frame(`PL_RAW_WIDTH * `PL_RAW_HEIGHT, int'(cur.gap));
            end
            wait_drain(4000);
        end
        repeat (50) @(posedge core_clk);
        $display("errors: %0d value, %0d stream, %0d check", value_errs, stream_errs, check_errs);
        if (value_errs + stream_errs + check_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- preview_link_top.sv
`include "preview_link_defs.svh"

module preview_link_top
    import preview_link_pkg::*;
(
    input  logic       core_clk,
    input  logic       sys_reset,

    // host commands
    input  host_byte_t host_byte_i,
    input  logic       host_byte_valid_i,

    // raw pixel stream
    input  pixel_t     pix_i,
    input  logic       pix_valid_i,
    input  logic       pix_sof_i,

    // output byte stream
    output host_byte_t tx_byte_o,
    output logic       tx_valid_o,
    input  logic       tx_ready_i,

    output logic       overflow_o
);

    cmd_t         cmd;
    crop_corner_t corner;
    pixel_entry_t wr_entry;
    logic         wr_en;
    pixel_entry_t rd_entry;
    logic         not_empty;
    logic         rd_pop;

    ////////////////////////////////////////////////////////////////////////
    // command path
    cmd_word_assembler i_cmd_word_assembler (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .cmd_o             (cmd)
    );

    crop_register_bank i_crop_register_bank (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .cmd_i     (cmd),
        .corner_o  (corner)
    );

    ////////////////////////////////////////////////////////////////////////
    // pixel path
    pixel_crop_tracker i_pixel_crop_tracker (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .corner_i    (corner),
        .wr_entry_o  (wr_entry),
        .wr_en_o     (wr_en)
    );

    pixel_fifo #(
        .DEPTH (`PL_FIFO_DEPTH)
    ) i_pixel_fifo (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .wr_entry_i  (wr_entry),
        .wr_en_i     (wr_en),
        .rd_pop_i    (rd_pop),
        .rd_entry_o  (rd_entry),
        .not_empty_o (not_empty),
        .overflow_o  (overflow_o)
    );

    frame_sequencer i_frame_sequencer (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .rd_entry_i  (rd_entry),
        .not_empty_i (not_empty),
        .rd_pop_o    (rd_pop),
        .tx_byte_o   (tx_byte_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i)
    );

endmodule

//--- frame_sequencer.sv
`include "preview_link_defs.svh"

module frame_sequencer
    import preview_link_pkg::*;
(
    input  logic         core_clk,
    input  logic         sys_reset,
    input  pixel_entry_t rd_entry_i,
    input  logic         not_empty_i,
    output logic         rd_pop_o,
    output host_byte_t   tx_byte_o,
    output logic         tx_valid_o,
    input  logic         tx_ready_i
);

    localparam int unsigned PIX_TOTAL = `PL_ROI_WIDTH * `PL_ROI_HEIGHT;
    localparam int CNT_W = $clog2(PIX_TOTAL + 1);
    localparam logic [63:0] MAGIC = `PL_MAGIC;

    seq_state_t       state_q;
    logic [2:0]       hdr_idx_q;
    logic [CNT_W-1:0] pix_cnt_q;
    logic             tx_fire;
    logic [5:0]       hdr_shift;

    // "B" sits in the top byte, so byte 0 comes from bit 56 down
    assign hdr_shift = {~hdr_idx_q, 3'b000};

    ////////////////////////////////////////////////////////////////////////
    // output and pop decode
    always_comb begin
        tx_valid_o = 1'b0;
        tx_byte_o  = rd_entry_i.data;
        rd_pop_o   = 1'b0;
        case (state_q)
            SEQ_IDLE: begin
                // drop leftovers until a frame start shows at the head
                rd_pop_o = not_empty_i && !rd_entry_i.first;
            end
            SEQ_HEADER: begin
                tx_valid_o = 1'b1;
                tx_byte_o  = MAGIC[hdr_shift +: 8];
            end
            SEQ_PAYLOAD: begin
                tx_valid_o = not_empty_i;
                rd_pop_o   = not_empty_i && tx_ready_i;
            end
            default: begin
                tx_valid_o = 1'b0;
            end
        endcase
        tx_fire = tx_valid_o && tx_ready_i;
    end

    ////////////////////////////////////////////////////////////////////////
    // state machine
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q   <= SEQ_IDLE;
            hdr_idx_q <= '0;
            pix_cnt_q <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    hdr_idx_q <= '0;
                    pix_cnt_q <= '0;
                    if (not_empty_i && rd_entry_i.first) begin
                        state_q <= SEQ_HEADER;
                    end
                end
                SEQ_HEADER: begin
                    if (tx_fire) begin
                        hdr_idx_q <= hdr_idx_q + 1'b1;
                        if (hdr_idx_q == 3'd7) begin
                            state_q <= SEQ_PAYLOAD;
                        end
                    end
                end
                SEQ_PAYLOAD: begin
                    if (tx_fire) begin
                        pix_cnt_q <= pix_cnt_q + 1'b1;
                        // last pixel of the cropped frame
                        if (pix_cnt_q == CNT_W'(PIX_TOTAL - 1)) begin
                            state_q <= SEQ_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

//--- pixel_fifo.sv
`include "preview_link_defs.svh"

module pixel_fifo
    import preview_link_pkg::*;
#(
    parameter int DEPTH = `PL_FIFO_DEPTH
) (
    input  logic         core_clk,
    input  logic         sys_reset,
    input  pixel_entry_t wr_entry_i,
    input  logic         wr_en_i,
    input  logic         rd_pop_i,
    output pixel_entry_t rd_entry_o,
    output logic         not_empty_o,
    output logic         overflow_o
);

    localparam int AW = $clog2(DEPTH);

    pixel_entry_t mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    always_comb begin
        full        = (count_q == (AW+1)'(DEPTH));
        not_empty_o = (count_q != '0);
        do_wr       = wr_en_i && !full;
        do_rd       = rd_pop_i && not_empty_o;
    end

    always_ff @(posedge core_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_entry_i;
        end
    end

    // head is visible straight from storage
    assign rd_entry_o = mem[rd_ptr_q];

    ////////////////////////////////////////////////////////////////////////
    // pointers, occupancy, sticky overflow
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (AW+1)'(do_wr) - (AW+1)'(do_rd);
            if (wr_en_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

//--- pixel_crop_tracker.sv
`include "preview_link_defs.svh"

module pixel_crop_tracker
    import preview_link_pkg::*;
(
    input  logic         core_clk,
    input  logic         sys_reset,
    input  pixel_t       pix_i,
    input  logic         pix_valid_i,
    input  logic         pix_sof_i,
    input  crop_corner_t corner_i,
    output pixel_entry_t wr_entry_o,
    output logic         wr_en_o
);

    coord_t       col_q;
    coord_t       row_q;
    coord_t       col_cur;
    coord_t       row_cur;
    crop_corner_t corner_q;
    crop_corner_t corner_cur;
    logic [16:0]  col_end;
    logic [16:0]  row_end;
    logic         in_window;
    logic         at_corner;

    ////////////////////////////////////////////////////////////////////////
    // position of the current pixel
    // sof forces (0,0) on its own pixel
    always_comb begin
        col_cur    = pix_sof_i ? '0 : col_q;
        row_cur    = pix_sof_i ? '0 : row_q;
        corner_cur = pix_sof_i ? corner_i : corner_q;
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q                <= '0;
            row_q                <= '0;
            corner_q.col_start   <= coord_t'(`PL_DEF_COL_START);
            corner_q.row_start   <= coord_t'(`PL_DEF_ROW_START);
        end else if (pix_valid_i) begin
            if (pix_sof_i) begin
                corner_q <= corner_i;
            end
            if (col_cur == coord_t'(`PL_RAW_WIDTH - 1)) begin
                col_q <= '0;
                if (row_cur == coord_t'(`PL_RAW_HEIGHT - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_cur + 1'b1;
                end
            end else begin
                col_q <= col_cur + 1'b1;
                row_q <= row_cur;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // window test, one bit wider so a corner near the top cannot wrap
    always_comb begin
        col_end   = {1'b0, corner_cur.col_start} + 17'(`PL_ROI_WIDTH);
        row_end   = {1'b0, corner_cur.row_start} + 17'(`PL_ROI_HEIGHT);
        in_window = (col_cur >= corner_cur.col_start) && ({1'b0, col_cur} < col_end) &&
                    (row_cur >= corner_cur.row_start) && ({1'b0, row_cur} < row_end);
        at_corner = (col_cur == corner_cur.col_start) && (row_cur == corner_cur.row_start);
    end

    always_ff @(posedge core_clk) begin
        wr_entry_o.data  <= pix_i;
        wr_entry_o.first <= at_corner;
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= pix_valid_i && in_window;
        end
    end

endmodule

//--- crop_register_bank.sv
`include "preview_link_defs.svh"

module crop_register_bank
    import preview_link_pkg::*;
(
    input  logic         core_clk,
    input  logic         sys_reset,
    input  cmd_t         cmd_i,
    output crop_corner_t corner_o
);

    coord_t col_start_q;
    coord_t row_start_q;
    logic   hit_col;
    logic   hit_row;

    ////////////////////////////////////////////////////////////////////////
    // address decode
    always_comb begin
        hit_col = cmd_i.valid && (cmd_i.addr == `PL_ADDR_COL_START);
        hit_row = cmd_i.valid && (cmd_i.addr == `PL_ADDR_ROW_START);
    end

    // only the low half of the data word is a coordinate
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_start_q <= coord_t'(`PL_DEF_COL_START);
            row_start_q <= coord_t'(`PL_DEF_ROW_START);
        end else begin
            if (hit_col) begin
                col_start_q <= cmd_i.data[15:0];
            end
            if (hit_row) begin
                row_start_q <= cmd_i.data[15:0];
            end
        end
    end

    // unknown addresses fall through untouched
    always_comb begin
        corner_o.col_start = col_start_q;
        corner_o.row_start = row_start_q;
    end

endmodule

//--- cmd_word_assembler.sv
`include "preview_link_defs.svh"

module cmd_word_assembler
    import preview_link_pkg::*;
(
    input  logic       core_clk,
    input  logic       sys_reset,
    input  host_byte_t host_byte_i,
    input  logic       host_byte_valid_i,
    output cmd_t       cmd_o
);

    localparam int CNT_W = $clog2(`PL_CMD_BYTES);

    logic [47:0]      word_q;
    logic [CNT_W-1:0] byte_cnt_q;
    logic             cmd_valid_q;

    // bytes arrive big-endian, so shifting left leaves addr on top
    always_ff @(posedge core_clk) begin
        if (host_byte_valid_i) begin
            word_q <= {word_q[39:0], host_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q  <= '0;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            if (host_byte_valid_i) begin
                if (byte_cnt_q == CNT_W'(`PL_CMD_BYTES - 1)) begin
                    byte_cnt_q  <= '0;
                    cmd_valid_q <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    // word_q holds all six bytes while the valid pulse is high
    always_comb begin
        cmd_o.valid = cmd_valid_q;
        cmd_o.addr  = word_q[47:32];
        cmd_o.data  = word_q[31:0];
    end

endmodule

//--- preview_link_pkg.sv
package preview_link_pkg;

    ////////////////////////////////////////////////////////////////////////
    // plain vectors
    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] coord_t;
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;
    typedef logic [7:0]  host_byte_t;

    ////////////////////////////////////////////////////////////////////////
    // bundles
    typedef struct packed {
        logic      valid;
        cmd_addr_t addr;
        cmd_data_t data;
    } cmd_t;

    typedef struct packed {
        coord_t col_start;
        coord_t row_start;
    } crop_corner_t;

    // first marks the corner pixel of a cropped frame
    typedef struct packed {
        logic   first;
        pixel_t data;
    } pixel_entry_t;

    // output sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_HEADER,
        SEQ_PAYLOAD
    } seq_state_t;

endpackage

//--- preview_link_defs.svh
`ifndef PREVIEW_LINK_DEFS_SVH
`define PREVIEW_LINK_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// image geometry
`define PL_RAW_WIDTH        16
`define PL_RAW_HEIGHT       8
`define PL_ROI_WIDTH        8
`define PL_ROI_HEIGHT       4

// crop corner after reset, centred horizontally
`define PL_DEF_COL_START    ((`PL_RAW_WIDTH - `PL_ROI_WIDTH) / 2)
`define PL_DEF_ROW_START    0

////////////////////////////////////////////////////////////////////////////
// host command map
`define PL_ADDR_COL_START   16'h0010
`define PL_ADDR_ROW_START   16'h0011
`define PL_CMD_BYTES        6

// "BIVFRAME", sent before every frame
`define PL_MAGIC            64'h4249_5646_5241_4D45

`define PL_FIFO_DEPTH       16

`endif
